// File: Makefile
# Verilator build and run of the pipeline control testbench.

VERILATOR ?= verilator
TOP       ?= tb_rv32_pipe_ctrl
FILELIST  ?= rv32_pipe_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_rv32_pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv32_pipe_ctrl
    import rv32_hazard_pkg::*;
;

    localparam int DIRECTED_CYCLES = 60;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int CYCLE_LIMIT     = DIRECTED_CYCLES + RANDOM_CYCLES + 100;
    localparam int TIMEOUT_WAITS   = 16;

    logic     clk;
    logic     arst_n;
    reg_idx_t decode_rs1;
    logic     decode_rs1_read;
    reg_idx_t decode_rs2;
    logic     decode_rs2_read;
    reg_idx_t decode_rd;
    logic     decode_rd_write;
    logic     decode_mem_read;
    logic     decode_mem_fence;
    logic     mem_branch_mispredicted;
    logic     instr_read;
    logic     instr_ready;
    logic     data_read;
    logic     data_write;
    logic     data_ready;

    logic     pcgen_stall;
    logic     fetch_stall;
    logic     fetch_flush;
    logic     decode_stall;
    logic     decode_flush;
    logic     execute_stall;
    logic     execute_flush;
    logic     mem_stall;
    logic     mem_flush;
    logic     writeback_flush;
    logic     instr_bus_timeout;
    logic     data_bus_timeout;

    // Model of the tracked pipeline fields and bus wait counts.
    reg_idx_t m_rd = '0;
    logic     m_rd_write = 1'b0;
    logic     m_mem_read = 1'b0;
    logic     m_dec_fence = 1'b0;
    logic     m_exe_fence = 1'b0;
    int       instr_waits = 0;
    int       data_waits = 0;

    logic [31:0] lcg_state = 32'd13679;
    int cycle_count = 0;
    int total_errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int fetch_stall_cycles = 0;
    int back_stall_cycles = 0;
    int flush_all_cycles = 0;
    int instr_timeouts = 0;
    int data_timeouts = 0;

    rv32_pipe_ctrl rv32_pipe_ctrl_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    task automatic check_signal(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s expected %h got %h at cycle %0d", name, exp, got, cycle_count);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic fail_check(input string what);
        $display("%s", what);
        test_errors++;
        total_errors++;
    endtask

    task automatic set_decode(input reg_idx_t rs1, input logic rs1_rd, input reg_idx_t rs2,
                              input logic rs2_rd, input reg_idx_t rd, input logic rd_wr,
                              input logic mem_rd, input logic fence);
        decode_rs1       = rs1;
        decode_rs1_read  = rs1_rd;
        decode_rs2       = rs2;
        decode_rs2_read  = rs2_rd;
        decode_rd        = rd;
        decode_rd_write  = rd_wr;
        decode_mem_read  = mem_rd;
        decode_mem_fence = fence;
    endtask

    task automatic set_bus(input logic i_rd, input logic i_rdy, input logic d_rd,
                           input logic d_wr, input logic d_rdy);
        instr_read  = i_rd;
        instr_ready = i_rdy;
        data_read   = d_rd;
        data_write  = d_wr;
        data_ready  = d_rdy;
    endtask

    // Compare just before the rising edge, then advance the model to the next falling edge.
    task automatic check_cycle();
        logic iwait, dwait, load_use, fence_wait;
        logic e_ex_stall, e_fe_stall, e_pc_stall;
        #9;
        iwait      = instr_read && !instr_ready;
        dwait      = (data_read || data_write) && !data_ready;
        load_use   = ((decode_rs1_read && decode_rs1 == m_rd)
                     || (decode_rs2_read && decode_rs2 == m_rd))
                     && (|m_rd) && m_mem_read && m_rd_write;
        fence_wait = decode_mem_fence || m_dec_fence || m_exe_fence;
        e_ex_stall = dwait;
        e_fe_stall = e_ex_stall || load_use || fence_wait;
        e_pc_stall = e_fe_stall || iwait;

        check_signal("pcgen_stall", pcgen_stall, e_pc_stall);
        check_signal("fetch_stall", fetch_stall, e_fe_stall);
        check_signal("fetch_flush", fetch_flush, e_pc_stall || mem_branch_mispredicted);
        check_signal("decode_stall", decode_stall, e_ex_stall);
        check_signal("decode_flush", decode_flush, e_fe_stall || mem_branch_mispredicted);
        check_signal("execute_stall", execute_stall, e_ex_stall);
        check_signal("execute_flush", execute_flush, e_ex_stall || mem_branch_mispredicted);
        check_signal("mem_stall", mem_stall, 1'b0);
        check_signal("mem_flush", mem_flush, e_ex_stall);
        check_signal("writeback_flush", writeback_flush, 1'b0);
        check_signal("instr_bus_timeout", instr_bus_timeout, instr_waits >= TIMEOUT_WAITS);
        check_signal("data_bus_timeout", data_bus_timeout, data_waits >= TIMEOUT_WAITS);

        if (fetch_stall) fetch_stall_cycles++;
        if (execute_stall) back_stall_cycles++;
        if (fetch_flush && decode_flush && execute_flush) flush_all_cycles++;
        if (instr_bus_timeout) instr_timeouts++;
        if (data_bus_timeout) data_timeouts++;

        // Execute goes first and takes the old decode-output fence.
        if (!e_ex_stall) begin
            m_exe_fence = (e_ex_stall || mem_branch_mispredicted) ? 1'b0 : m_dec_fence;
            if (e_fe_stall || mem_branch_mispredicted) begin
                m_rd        = '0;
                m_rd_write  = 1'b0;
                m_mem_read  = 1'b0;
                m_dec_fence = 1'b0;
            end else begin
                m_rd        = decode_rd;
                m_rd_write  = decode_rd_write;
                m_mem_read  = decode_mem_read;
                m_dec_fence = decode_mem_fence;
            end
        end
        instr_waits = iwait ? ((instr_waits < TIMEOUT_WAITS) ? instr_waits + 1 : instr_waits) : 0;
        data_waits  = dwait ? ((data_waits < TIMEOUT_WAITS) ? data_waits + 1 : data_waits) : 0;
        @(negedge clk);
    endtask

    task automatic start_test();
        test_errors        = 0;
        fetch_stall_cycles = 0;
        back_stall_cycles  = 0;
        flush_all_cycles   = 0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %-10s ok", name);
        end else begin
            tests_failed++;
            $display("test %-10s failed with %0d errors", name, test_errors);
        end
    endtask

    task automatic load_use_sequence(input reg_idx_t rd, input logic read_en);
        set_decode(5'd0, 1'b0, 5'd0, 1'b0, rd, 1'b1, 1'b1, 1'b0);
        check_cycle();
        set_decode(rd, read_en, 5'd0, 1'b0, 5'd6, 1'b1, 1'b0, 1'b0);
        check_cycle();
        check_cycle();
        set_decode(5'd0, 1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 1'b0, 1'b0);
        check_cycle();
    endtask

    task automatic random_inputs();
        logic [15:0] r;
        logic        data_req;
        r = next_rand();
        set_decode({2'b00, r[2:0]}, r[3], {2'b00, r[6:4]}, r[7], {2'b00, r[10:8]},
                   r[11], r[12], 1'b0);
        r = next_rand();
        decode_mem_fence        = (r[3:0] == 4'd0);
        mem_branch_mispredicted = (r[7:4] == 4'd0);
        instr_read              = (r[11:8] != 4'd0);
        r = next_rand();
        // Ready is rare so that some waits run past the timeout.
        instr_ready = (r[3:0] == 4'd0);
        data_req    = (r[7:4] != 4'd0);
        data_read   = data_req && r[8];
        data_write  = data_req && !r[8];
        data_ready  = (r[12:9] == 4'd0);
    endtask

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles without finishing", CYCLE_LIMIT);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        arst_n = 1'b0;
        mem_branch_mispredicted = 1'b0;
        set_decode(5'd0, 1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 1'b0, 1'b0);
        set_bus(1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        start_test();
        repeat (4) check_cycle();
        end_test("reset");

        start_test();
        load_use_sequence(5'd5, 1'b1);
        if (fetch_stall_cycles != 1) fail_check("load-use on x5 did not stall exactly one cycle");
        fetch_stall_cycles = 0;
        load_use_sequence(5'd0, 1'b1);
        load_use_sequence(5'd5, 1'b0);
        if (fetch_stall_cycles != 0) fail_check("load-use stalled on x0 or an unread source");
        end_test("load_use");

        start_test();
        set_decode(5'd0, 1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 1'b0, 1'b1);
        repeat (3) check_cycle();
        set_decode(5'd0, 1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 1'b0, 1'b0);
        repeat (2) check_cycle();
        if (fetch_stall_cycles != 3) fail_check("fence did not hold fetch for three cycles");
        if (back_stall_cycles != 0) fail_check("fence stalled execute");
        end_test("fence");

        start_test();
        set_bus(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        repeat (2) check_cycle();
        if (fetch_stall_cycles != 0 || back_stall_cycles != 0) begin
            fail_check("instruction bus wait stalled a stage past pcgen");
        end
        set_bus(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        repeat (2) check_cycle();
        set_bus(1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        check_cycle();
        if (back_stall_cycles != 2) fail_check("data bus wait did not stall execute");
        end_test("bus_wait");

        start_test();
        mem_branch_mispredicted = 1'b1;
        check_cycle();
        mem_branch_mispredicted = 1'b0;
        check_cycle();
        if (flush_all_cycles != 1) fail_check("mispredict did not flush the front stages once");
        end_test("mispredict");

        start_test();
        instr_timeouts = 0;
        data_timeouts  = 0;
        repeat (RANDOM_CYCLES) begin
            random_inputs();
            check_cycle();
        end
        if (instr_timeouts == 0 || data_timeouts == 0) begin
            fail_check("random run never reached a bus timeout");
        end
        end_test("random");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/rv32_bus_wait.sv
`timescale 1ns/1ps
`default_nettype none

module rv32_bus_wait
    import rv32_hazard_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,

    input  logic       instr_read,
    input  logic       instr_ready,

    input  logic       data_read,
    input  logic       data_write,
    input  logic       data_ready,

    hazard_wait_if.bus wait_o,

    output logic       instr_bus_timeout,
    output logic       data_bus_timeout
);

    // Bit 0 is the instruction bus, bit 1 the data bus.
    logic [1:0] bus_wait;
    logic [1:0] bus_timeout;

    assign bus_wait[0] = instr_read && !instr_ready;
    assign bus_wait[1] = (data_read || data_write) && !data_ready;

    assign wait_o.pcgen_wait_for_bus   = bus_wait[0];
    assign wait_o.execute_wait_for_bus = bus_wait[1];

    for (genvar b = 0; b < 2; b++) begin : g_bus
        bus_mon_state_t state;
        bus_mon_state_t state_next;
        bus_wait_cnt_t  wait_cnt;
        bus_wait_cnt_t  wait_cnt_next;

        always_comb begin
            state_next    = state;
            wait_cnt_next = wait_cnt;
            case (state)
                BUS_IDLE: begin
                    if (bus_wait[b]) begin
                        state_next    = BUS_WAIT;
                        wait_cnt_next = 5'd1;
                    end
                end
                BUS_WAIT: begin
                    if (!bus_wait[b]) begin
                        state_next    = BUS_IDLE;
                        wait_cnt_next = '0;
                    end else begin
                        wait_cnt_next = wait_cnt + 5'd1;
                        if (wait_cnt_next == BUS_TIMEOUT_CYCLES) begin
                            state_next = BUS_TIMEOUT;
                        end
                    end
                end
                BUS_TIMEOUT: begin
                    // Count saturates here until the wait ends.
                    if (!bus_wait[b]) begin
                        state_next    = BUS_IDLE;
                        wait_cnt_next = '0;
                    end
                end
                default: begin
                    state_next    = BUS_IDLE;
                    wait_cnt_next = '0;
                end
            endcase
        end

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                state    <= BUS_IDLE;
                wait_cnt <= '0;
            end else begin
                state    <= state_next;
                wait_cnt <= wait_cnt_next;
            end
        end

        assign bus_timeout[b] = (state == BUS_TIMEOUT);

        a_timeout_needs_wait: assert property (
            @(posedge clk) disable iff (!arst_n)
            bus_timeout[b] |-> (state != BUS_IDLE) && $past(bus_wait[b])
        );
    end

    assign instr_bus_timeout = bus_timeout[0];
    assign data_bus_timeout  = bus_timeout[1];

endmodule

`default_nettype wire

// File: hdl/rv32_hazard_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Wait conditions raised by the two detectors.
interface hazard_wait_if;

    logic pcgen_wait_for_bus;
    logic fetch_wait_for_mem_read;
    logic fetch_wait_for_mem_fence;
    logic execute_wait_for_bus;

    modport operand (
        output fetch_wait_for_mem_read,
        output fetch_wait_for_mem_fence
    );

    modport bus (
        output pcgen_wait_for_bus,
        output execute_wait_for_bus
    );

    modport combiner (
        input pcgen_wait_for_bus,
        input fetch_wait_for_mem_read,
        input fetch_wait_for_mem_fence,
        input execute_wait_for_bus
    );

endinterface

// Per-stage stall and flush levels.
interface stage_ctrl_if;

    logic pcgen_stall;
    logic fetch_stall;
    logic fetch_flush;
    logic decode_stall;
    logic decode_flush;
    logic execute_stall;
    logic execute_flush;
    logic mem_flush;
    logic writeback_flush;

    modport source (
        output pcgen_stall,
        output fetch_stall,
        output fetch_flush,
        output decode_stall,
        output decode_flush,
        output execute_stall,
        output execute_flush,
        output mem_flush,
        output writeback_flush
    );

    modport tracker (
        input decode_stall,
        input decode_flush,
        input execute_stall,
        input execute_flush
    );

endinterface

`default_nettype wire

// File: hdl/rv32_hazard_pkg.sv
`default_nettype none

package rv32_hazard_pkg;

    // Architectural register index.
    typedef logic [4:0] reg_idx_t;

    // Consecutive wait cycles seen on one bus.
    typedef logic [4:0] bus_wait_cnt_t;

    typedef enum logic [1:0] {
        BUS_IDLE    = 2'd0,
        BUS_WAIT    = 2'd1,
        BUS_TIMEOUT = 2'd2
    } bus_mon_state_t;

    // Wait cycles before a bus is flagged.
    localparam bus_wait_cnt_t BUS_TIMEOUT_CYCLES = 5'd16;

endpackage

`default_nettype wire

// File: hdl/rv32_hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rv32_hazard_unit (
    hazard_wait_if.combiner wait_i,

    input  logic            mem_branch_mispredicted,

    stage_ctrl_if.source    ctrl
);

    // Stalls propagate backwards, each stage also holds for the one after it.
    assign ctrl.execute_stall = wait_i.execute_wait_for_bus;
    assign ctrl.decode_stall  = ctrl.execute_stall;
    assign ctrl.fetch_stall   = ctrl.decode_stall
                                || wait_i.fetch_wait_for_mem_read
                                || wait_i.fetch_wait_for_mem_fence;
    assign ctrl.pcgen_stall   = ctrl.fetch_stall || wait_i.pcgen_wait_for_bus;

    // A stalled producer leaves a bubble in the stage after it.
    assign ctrl.fetch_flush   = ctrl.pcgen_stall || mem_branch_mispredicted;
    assign ctrl.decode_flush  = ctrl.fetch_stall || mem_branch_mispredicted;
    assign ctrl.execute_flush = ctrl.decode_stall || mem_branch_mispredicted;

    // Mispredict resolves in memory, so that stage keeps its instruction.
    assign ctrl.mem_flush       = ctrl.execute_stall;
    assign ctrl.writeback_flush = 1'b0;

endmodule

`default_nettype wire

// File: hdl/rv32_operand_hazard.sv
`timescale 1ns/1ps
`default_nettype none

module rv32_operand_hazard
    import rv32_hazard_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,

    input  reg_idx_t       decode_rs1,
    input  logic           decode_rs1_read,
    input  reg_idx_t       decode_rs2,
    input  logic           decode_rs2_read,

    input  reg_idx_t       decode_rd,
    input  logic           decode_rd_write,
    input  logic           decode_mem_read,
    input  logic           decode_mem_fence,

    stage_ctrl_if.tracker  ctrl,
    hazard_wait_if.operand wait_o
);

    // Copy of the decode output register.
    reg_idx_t dec_rd;
    logic     dec_rd_write;
    logic     dec_mem_read;
    logic     dec_mem_fence;

    // Copy of the execute output register, only the fence matters here.
    logic     exe_mem_fence;

    logic     rs1_match;
    logic     rs2_match;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_rd        <= '0;
            dec_rd_write  <= 1'b0;
            dec_mem_read  <= 1'b0;
            dec_mem_fence <= 1'b0;
        end else if (!ctrl.decode_stall) begin
            if (ctrl.decode_flush) begin
                dec_rd        <= '0;
                dec_rd_write  <= 1'b0;
                dec_mem_read  <= 1'b0;
                dec_mem_fence <= 1'b0;
            end else begin
                dec_rd        <= decode_rd;
                dec_rd_write  <= decode_rd_write;
                dec_mem_read  <= decode_mem_read;
                dec_mem_fence <= decode_mem_fence;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exe_mem_fence <= 1'b0;
        end else if (!ctrl.execute_stall) begin
            if (ctrl.execute_flush) begin
                exe_mem_fence <= 1'b0;
            end else begin
                exe_mem_fence <= dec_mem_fence;
            end
        end
    end

    assign rs1_match = decode_rs1_read && (decode_rs1 == dec_rd);
    assign rs2_match = decode_rs2_read && (decode_rs2 == dec_rd);

    // Load result is not ready until the memory stage, x0 never hazards.
    assign wait_o.fetch_wait_for_mem_read = (rs1_match || rs2_match) && (|dec_rd)
                                            && dec_mem_read && dec_rd_write;

    // Hold fetch until the fence has left execute.
    assign wait_o.fetch_wait_for_mem_fence = decode_mem_fence || dec_mem_fence
                                             || exe_mem_fence;

    a_decode_bubble: assert property (
        @(posedge clk) disable iff (!arst_n)
        ctrl.decode_flush && !ctrl.decode_stall
            |=> !dec_rd_write && !dec_mem_read && !dec_mem_fence
    );

    a_execute_bubble: assert property (
        @(posedge clk) disable iff (!arst_n)
        ctrl.execute_flush && !ctrl.execute_stall |=> !exe_mem_fence
    );

endmodule

`default_nettype wire

// File: hdl/rv32_pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rv32_pipe_ctrl
    import rv32_hazard_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    input  reg_idx_t decode_rs1,
    input  logic     decode_rs1_read,
    input  reg_idx_t decode_rs2,
    input  logic     decode_rs2_read,
    input  reg_idx_t decode_rd,
    input  logic     decode_rd_write,
    input  logic     decode_mem_read,
    input  logic     decode_mem_fence,

    input  logic     mem_branch_mispredicted,

    input  logic     instr_read,
    input  logic     instr_ready,
    input  logic     data_read,
    input  logic     data_write,
    input  logic     data_ready,

    output logic     pcgen_stall,
    output logic     fetch_stall,
    output logic     fetch_flush,
    output logic     decode_stall,
    output logic     decode_flush,
    output logic     execute_stall,
    output logic     execute_flush,
    output logic     mem_stall,
    output logic     mem_flush,
    output logic     writeback_flush,

    output logic     instr_bus_timeout,
    output logic     data_bus_timeout
);

    hazard_wait_if wait_bus ();
    stage_ctrl_if  stage_ctrl ();

    rv32_operand_hazard operand_hazard_inst (
        .clk              (clk),
        .arst_n           (arst_n),
        .decode_rs1       (decode_rs1),
        .decode_rs1_read  (decode_rs1_read),
        .decode_rs2       (decode_rs2),
        .decode_rs2_read  (decode_rs2_read),
        .decode_rd        (decode_rd),
        .decode_rd_write  (decode_rd_write),
        .decode_mem_read  (decode_mem_read),
        .decode_mem_fence (decode_mem_fence),
        .ctrl             (stage_ctrl),
        .wait_o           (wait_bus)
    );

    rv32_bus_wait bus_wait_inst (
        .clk               (clk),
        .arst_n            (arst_n),
        .instr_read        (instr_read),
        .instr_ready       (instr_ready),
        .data_read         (data_read),
        .data_write        (data_write),
        .data_ready        (data_ready),
        .wait_o            (wait_bus),
        .instr_bus_timeout (instr_bus_timeout),
        .data_bus_timeout  (data_bus_timeout)
    );

    rv32_hazard_unit hazard_unit_inst (
        .wait_i                  (wait_bus),
        .mem_branch_mispredicted (mem_branch_mispredicted),
        .ctrl                    (stage_ctrl)
    );

    assign pcgen_stall     = stage_ctrl.pcgen_stall;
    assign fetch_stall     = stage_ctrl.fetch_stall;
    assign fetch_flush     = stage_ctrl.fetch_flush;
    assign decode_stall    = stage_ctrl.decode_stall;
    assign decode_flush    = stage_ctrl.decode_flush;
    assign execute_stall   = stage_ctrl.execute_stall;
    assign execute_flush   = stage_ctrl.execute_flush;
    assign mem_flush       = stage_ctrl.mem_flush;
    assign writeback_flush = stage_ctrl.writeback_flush;

    // Memory stage never waits.
    assign mem_stall = 1'b0;

    a_no_writeback_flush: assert property (
        @(posedge clk) disable iff (!arst_n)
        !writeback_flush
    );

endmodule

`default_nettype wire

// File: rv32_pipe_ctrl.f
hdl/rv32_hazard_pkg.sv
hdl/rv32_hazard_ifs.sv
hdl/rv32_operand_hazard.sv
hdl/rv32_bus_wait.sv
hdl/rv32_hazard_unit.sv
hdl/rv32_pipe_ctrl.sv
dv/tb_rv32_pipe_ctrl.sv
